// ==== filelist.f ====
src/mmu_pkg.sv
src/tlb_entry_array.sv
src/tlb_match.sv
src/tlb_translate.sv
src/cp0_tlb_regs.sv
src/mmu_top.sv
dv/mmu_checker.sv
dv/mmu_tb.sv

// ==== dv/mmu_tb.sv ====
module mmu_tb;

    localparam int TLB_ENTRIES = mmu_pkg::DEFAULT_TLB_ENTRIES;
    localparam int CLK_PERIOD  = 4;
    localparam int N_TRAFFIC   = 200;
    localparam int N_OPS       = 2 * N_TRAFFIC + TLB_ENTRIES * 5 + 120;

    // implemented bits of each cp0 word
    localparam logic [31:0] HI_MASK  = 32'hFFFF_E0FF;
    localparam logic [31:0] LO_MASK  = 32'h03FF_FFC7;
    localparam logic [31:0] IDX_MASK = 32'h8000_0000 | (TLB_ENTRIES - 1);

    logic aclk, reset;
    logic if_req_valid, if_allowin, if_rsp_valid, if_rsp_allowin;
    logic dm_req_valid, dm_is_store, dm_allowin, dm_rsp_valid, dm_rsp_allowin;
    mmu_pkg::vaddr_t   if_vaddr, dm_vaddr;
    mmu_pkg::paddr_t   if_paddr, dm_paddr;
    mmu_pkg::mmu_exc_t if_exc, dm_exc;
    logic        cp0_wen, tlbwi, tlbp;
    logic [4:0]  cp0_waddr, cp0_raddr;
    logic [31:0] cp0_wdata, cp0_rdata;

    // reference model of the cp0 words and the table
    logic [31:0] ref_hi, ref_lo0w, ref_lo1w, ref_index;
    logic [18:0] ref_vpn2 [TLB_ENTRIES];
    logic [7:0]  ref_asid [TLB_ENTRIES];
    logic [31:0] ref_lo0 [TLB_ENTRIES];
    logic [31:0] ref_lo1 [TLB_ENTRIES];
    logic        traffic_done;

    mmu_top #(.TLB_ENTRIES(TLB_ENTRIES)) u_dut (.*);

    mmu_checker u_chk (.*);

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    function automatic logic [33:0] translate_ref(input logic [31:0] va, input logic st,
                                                  input logic [7:0] asid);
        logic [31:0] lo;
        logic        hit;
        logic [33:0] res;
        hit = 1'b0;
        res = {32'd0, mmu_pkg::EXC_REFILL};
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (!hit && ref_vpn2[i] == va[31:13] &&
                ((ref_lo0[i][0] && ref_lo1[i][0]) || ref_asid[i] == asid)) begin
                hit = 1'b1;
                lo  = va[12] ? ref_lo1[i] : ref_lo0[i];   // odd page on bit 12
                if (!lo[1])
                    res = {32'd0, mmu_pkg::EXC_INVALID};
                else if (st && !lo[2])
                    res = {32'd0, mmu_pkg::EXC_MODIFIED};
                else
                    res = {lo[25:6], va[11:0], mmu_pkg::EXC_NONE};
            end
        end
        return res;
    endfunction

    function automatic logic [31:0] make_lo(input logic [19:0] pfn, input logic d,
                                            input logic v, input logic g);
        return {6'd0, pfn, 3'd0, d, v, g};
    endfunction

    function automatic logic [31:0] cp0_model(input logic [4:0] addr);
        case (addr)
            mmu_pkg::CP0_INDEX:    return ref_index;
            mmu_pkg::CP0_ENTRYLO0: return ref_lo0w;
            mmu_pkg::CP0_ENTRYLO1: return ref_lo1w;
            mmu_pkg::CP0_ENTRYHI:  return ref_hi;
            default:               return 32'd0;
        endcase
    endfunction

    // expected results queued at the accepting edge
    always @(posedge aclk) begin
        if (!reset && if_req_valid && if_allowin)
            u_chk.push_fetch(translate_ref(if_vaddr, 1'b0, ref_hi[7:0]));
        if (!reset && dm_req_valid && dm_allowin)
            u_chk.push_data(translate_ref(dm_vaddr, dm_is_store, ref_hi[7:0]));
    end

    task automatic cp0_write(input logic [4:0] addr, input logic [31:0] data);
        cp0_wen   = 1'b1;
        cp0_waddr = addr;
        cp0_wdata = data;
        case (addr)
            mmu_pkg::CP0_INDEX:    ref_index = data & IDX_MASK;
            mmu_pkg::CP0_ENTRYLO0: ref_lo0w  = data & LO_MASK;
            mmu_pkg::CP0_ENTRYLO1: ref_lo1w  = data & LO_MASK;
            mmu_pkg::CP0_ENTRYHI:  ref_hi    = data & HI_MASK;
            default: ;
        endcase
        @(negedge aclk);
        cp0_wen = 1'b0;
    endtask

    task automatic cp0_check(input logic [4:0] addr);
        cp0_raddr = addr;
        u_chk.push_cp0(cp0_model(addr));
        @(negedge aclk);
    endtask

    task automatic tlb_write(input int idx, input logic [18:0] vpn2, input logic [7:0] asid,
                             input logic [31:0] lo0, input logic [31:0] lo1);
        cp0_write(mmu_pkg::CP0_INDEX, idx);
        cp0_write(mmu_pkg::CP0_ENTRYHI, {vpn2, 5'd0, asid});
        cp0_write(mmu_pkg::CP0_ENTRYLO0, lo0);
        cp0_write(mmu_pkg::CP0_ENTRYLO1, lo1);
        tlbwi = 1'b1;
        ref_vpn2[idx] = ref_hi[31:13];
        ref_asid[idx] = ref_hi[7:0];
        ref_lo0[idx]  = ref_lo0w;
        ref_lo1[idx]  = ref_lo1w;
        @(negedge aclk);
        tlbwi = 1'b0;
    endtask

    task automatic probe(input logic [18:0] vpn2, input logic [7:0] asid);
        logic hit;
        hit = 1'b0;
        cp0_write(mmu_pkg::CP0_ENTRYHI, {vpn2, 5'd0, asid});
        tlbp = 1'b1;
        @(negedge aclk);
        tlbp = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (!hit && ref_vpn2[i] == vpn2 &&
                ((ref_lo0[i][0] && ref_lo1[i][0]) || ref_asid[i] == asid)) begin
                hit = 1'b1;
                ref_index = i;
            end
        end
        if (!hit)
            ref_index[31] = 1'b1;   // index bits kept
        cp0_check(mmu_pkg::CP0_INDEX);
    endtask

    task automatic wait_accept(input int port);
        logic acc;
        acc = 1'b0;
        while (!acc) begin
            @(posedge aclk);
            acc = (port == 0) ? if_allowin : dm_allowin;
        end
        @(negedge aclk);
    endtask

    task automatic lookup(input int port, input logic [31:0] va, input logic st);
        if (port == 0) begin
            if_req_valid = 1'b1;
            if_vaddr     = va;
        end else begin
            dm_req_valid = 1'b1;
            dm_vaddr     = va;
            dm_is_store  = st;
        end
        wait_accept(port);
        if (port == 0) begin
            if_req_valid = 1'b0;
        end else begin
            dm_req_valid = 1'b0;
        end
    endtask

    function automatic logic [31:0] pick_vaddr();
        int i;
        if ($urandom % 4 == 0)
            return $urandom;   // mostly unmapped
        i = $urandom % TLB_ENTRIES;
        return {ref_vpn2[i], 13'($urandom)};
    endfunction

    task automatic drive_traffic(input int port);
        repeat (N_TRAFFIC) begin
            repeat ($urandom % 3) @(negedge aclk);
            lookup(port, pick_vaddr(), 1'($urandom));
        end
    endtask

    initial begin
        int seed;
        int n;
        int missing;
        logic [18:0] v0, v1;
        seed = 45;
        void'($urandom(seed));
        reset = 1'b1;
        {if_req_valid, dm_req_valid, dm_is_store, cp0_wen, tlbwi, tlbp} = '0;
        {if_rsp_allowin, dm_rsp_allowin} = 2'b11;
        if_vaddr = '0;
        dm_vaddr = '0;
        cp0_waddr = '0;
        cp0_wdata = '0;
        cp0_raddr = '0;
        {ref_hi, ref_lo0w, ref_lo1w, ref_index} = '0;
        traffic_done = 1'b0;
        repeat (8) @(negedge aclk);
        reset = 1'b0;

        // registers clear out of reset and unknown addresses read zero
        cp0_check(mmu_pkg::CP0_INDEX);
        cp0_check(mmu_pkg::CP0_ENTRYLO0);
        cp0_check(mmu_pkg::CP0_ENTRYLO1);
        cp0_check(mmu_pkg::CP0_ENTRYHI);
        cp0_check(5'd7);
        repeat (4) begin
            cp0_write(mmu_pkg::CP0_INDEX, $urandom);
            cp0_check(mmu_pkg::CP0_INDEX);
            cp0_write(mmu_pkg::CP0_ENTRYLO0, $urandom);
            cp0_check(mmu_pkg::CP0_ENTRYLO0);
            cp0_write(mmu_pkg::CP0_ENTRYLO1, $urandom);
            cp0_check(mmu_pkg::CP0_ENTRYLO1);
            cp0_write(mmu_pkg::CP0_ENTRYHI, $urandom);
            cp0_check(mmu_pkg::CP0_ENTRYHI);
        end

        // low vpn2 bits hold the slot, so no two entries collide
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            logic g;
            g = ($urandom % 4 == 0);
            tlb_write(i, {15'($urandom), 4'(i)}, ($urandom % 2) ? 8'h5A : 8'($urandom),
                      make_lo(20'($urandom), 1'($urandom), $urandom % 4 != 0, g),
                      make_lo(20'($urandom), 1'($urandom), $urandom % 4 != 0, g));
        end

        v0 = {15'h1234, 4'd0};
        v1 = {15'h0ABC, 4'd1};
        tlb_write(0, v0, 8'h5A,
                  make_lo(20'hABCDE, 1'b0, 1'b1, 1'b0),
                  make_lo(20'h1, 1'b1, 1'b0, 1'b0));
        tlb_write(1, v1, 8'h33,
                  make_lo(20'h55AA5, 1'b1, 1'b1, 1'b1),
                  make_lo(20'h2, 1'b1, 1'b1, 1'b1));
        cp0_write(mmu_pkg::CP0_ENTRYHI, {19'd0, 5'd0, 8'h5A});
        lookup(0, {v0, 1'b0, 12'h123}, 1'b0);   // mapped even page
        lookup(1, {v0, 1'b0, 12'h456}, 1'b0);   // load of clean page
        lookup(1, {v0, 1'b0, 12'h789}, 1'b1);   // store of clean page
        lookup(0, {v0, 1'b1, 12'h000}, 1'b0);   // odd page not valid
        lookup(1, {v1, 1'b1, 12'hFFF}, 1'b1);
        lookup(0, {15'h7FFF, 4'd0, 13'h0042}, 1'b0);
        cp0_write(mmu_pkg::CP0_ENTRYHI, {19'd0, 5'd0, 8'h77});
        lookup(0, {v1, 1'b0, 12'h321}, 1'b0);   // global under another asid
        lookup(1, {v0, 1'b0, 12'h321}, 1'b0);

        probe(v1, 8'h01);
        probe({15'h7FFF, 4'd0}, 8'h5A);
        for (int i = 2; i < 8; i++)
            probe(ref_vpn2[i], ref_asid[i]);

        // both ports with random back-pressure
        cp0_write(mmu_pkg::CP0_ENTRYHI, {19'd0, 5'd0, 8'h5A});
        fork
            begin
                fork
                    drive_traffic(0);
                    drive_traffic(1);
                join
                traffic_done = 1'b1;
            end
            while (!traffic_done) begin
                if_rsp_allowin = ($urandom % 3 != 0);
                dm_rsp_allowin = ($urandom % 3 != 0);
                @(negedge aclk);
            end
        join
        if_rsp_allowin = 1'b1;
        dm_rsp_allowin = 1'b1;

        n = 0;
        while (u_chk.pending() != 0 && n < 50) begin
            @(negedge aclk);
            n++;
        end
        missing = u_chk.pending();
        if (missing != 0)
            $display("%0d expected responses never arrived", missing);
        $display("errors: mismatch %0d, protocol %0d, missing %0d",
                 u_chk.mismatch_count, u_chk.protocol_count, missing);
        if (u_chk.mismatch_count + u_chk.protocol_count + missing == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(N_OPS * 20 * CLK_PERIOD);
        $display("watchdog expired, the run hung before all operations finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== dv/mmu_checker.sv ====
module mmu_checker (
    input logic              aclk,
    input logic              reset,
    input logic              if_req_valid,
    input logic              if_allowin,
    input logic              if_rsp_valid,
    input logic              if_rsp_allowin,
    input mmu_pkg::paddr_t   if_paddr,
    input mmu_pkg::mmu_exc_t if_exc,
    input logic              dm_req_valid,
    input logic              dm_allowin,
    input logic              dm_rsp_valid,
    input logic              dm_rsp_allowin,
    input mmu_pkg::paddr_t   dm_paddr,
    input mmu_pkg::mmu_exc_t dm_exc,
    input logic [31:0]       cp0_rdata
);

    // expected {paddr, exc} per port
    logic [33:0] fetch_q [$];
    logic [33:0] data_q [$];
    logic [31:0] cp0_q [$];

    int mismatch_count = 0;
    int protocol_count = 0;

    logic        if_acc_q;   // accepted on the previous edge
    logic        dm_acc_q;
    logic        if_stall_q; // result held back on the previous edge
    logic        dm_stall_q;
    logic [33:0] if_held_q;
    logic [33:0] dm_held_q;
    logic [31:0] cp0_exp;

    task automatic push_fetch(input logic [33:0] e);
        fetch_q.push_back(e);
    endtask

    task automatic push_data(input logic [33:0] e);
        data_q.push_back(e);
    endtask

    task automatic push_cp0(input logic [31:0] e);
        cp0_q.push_back(e);
    endtask

    function automatic int pending();
        return fetch_q.size() + data_q.size();
    endfunction

    task automatic compare_rsp(input string port, input logic [33:0] exp, input logic [33:0] got);
        if (got !== exp) begin
            mismatch_count++;
            $display("** Error at %0t: %s port expected paddr %h exc %0d, got paddr %h exc %0d",
                     $time, port, exp[33:2], exp[1:0], got[33:2], got[1:0]);
        end
    endtask

    always @(posedge aclk) begin
        if (reset) begin
            if_acc_q   <= 1'b0;
            dm_acc_q   <= 1'b0;
            if_stall_q <= 1'b0;
            dm_stall_q <= 1'b0;
        end else begin
            // an accept always lands in the output register next cycle
            if (if_acc_q && !if_rsp_valid) begin
                protocol_count++;
                $display("fetch result did not appear one cycle after accept, time %0t", $time);
            end
            if (dm_acc_q && !dm_rsp_valid) begin
                protocol_count++;
                $display("data result did not appear one cycle after accept, time %0t", $time);
            end
            if_acc_q <= if_req_valid && if_allowin;
            dm_acc_q <= dm_req_valid && dm_allowin;

            // a stalled result must stay put until it is taken
            if (if_stall_q && (!if_rsp_valid || {if_paddr, if_exc} !== if_held_q)) begin
                protocol_count++;
                $display("fetch result changed while held back, time %0t", $time);
            end
            if (dm_stall_q && (!dm_rsp_valid || {dm_paddr, dm_exc} !== dm_held_q)) begin
                protocol_count++;
                $display("data result changed while held back, time %0t", $time);
            end
            if_stall_q <= if_rsp_valid && !if_rsp_allowin;
            dm_stall_q <= dm_rsp_valid && !dm_rsp_allowin;
            if_held_q  <= {if_paddr, if_exc};
            dm_held_q  <= {dm_paddr, dm_exc};

            if (if_rsp_valid && if_rsp_allowin) begin
                if (fetch_q.size() == 0) begin
                    protocol_count++;
                    $display("unexpected response on fetch port at time %0t", $time);
                end else begin
                    compare_rsp("fetch", fetch_q.pop_front(), {if_paddr, if_exc});
                end
            end
            if (dm_rsp_valid && dm_rsp_allowin) begin
                if (data_q.size() == 0) begin
                    protocol_count++;
                    $display("unexpected response on data port at time %0t", $time);
                end else begin
                    compare_rsp("data", data_q.pop_front(), {dm_paddr, dm_exc});
                end
            end

            if (cp0_q.size() != 0) begin
                cp0_exp = cp0_q.pop_front();
                if (cp0_rdata !== cp0_exp) begin
                    mismatch_count++;
                    $display("** Error at %0t: cp0 read expected %h, got %h",
                             $time, cp0_exp, cp0_rdata);
                end
            end
        end
    end

endmodule

// ==== src/mmu_top.sv ====
module mmu_top #(
    parameter int TLB_ENTRIES = mmu_pkg::DEFAULT_TLB_ENTRIES
) (
    input  logic              aclk,
    input  logic              reset,
    // fetch search port
    input  logic              if_req_valid,
    input  mmu_pkg::vaddr_t   if_vaddr,
    output logic              if_allowin,
    output logic              if_rsp_valid,
    input  logic              if_rsp_allowin,
    output mmu_pkg::paddr_t   if_paddr,
    output mmu_pkg::mmu_exc_t if_exc,
    // data search port
    input  logic              dm_req_valid,
    input  mmu_pkg::vaddr_t   dm_vaddr,
    input  logic              dm_is_store,
    output logic              dm_allowin,
    output logic              dm_rsp_valid,
    input  logic              dm_rsp_allowin,
    output mmu_pkg::paddr_t   dm_paddr,
    output mmu_pkg::mmu_exc_t dm_exc,
    // cp0 access
    input  logic              cp0_wen,
    input  logic [4:0]        cp0_waddr,
    input  logic [31:0]       cp0_wdata,
    input  logic [4:0]        cp0_raddr,
    output logic [31:0]       cp0_rdata,
    input  logic              tlbwi,
    input  logic              tlbp
);

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    mmu_pkg::tlb_entry_t entries [TLB_ENTRIES];

    mmu_pkg::vpn2_t      cur_vpn2;
    mmu_pkg::asid_t      cur_asid;
    logic                tlb_wen;
    logic [IDX_W-1:0]    tlb_widx;
    mmu_pkg::tlb_entry_t tlb_wentry;
    logic                probe_found;
    logic [IDX_W-1:0]    probe_index;

    cp0_tlb_regs #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_cp0 (
        .aclk        (aclk),
        .reset       (reset),
        .wen         (cp0_wen),
        .waddr       (cp0_waddr),
        .wdata       (cp0_wdata),
        .raddr       (cp0_raddr),
        .rdata       (cp0_rdata),
        .tlbwi       (tlbwi),
        .tlbp        (tlbp),
        .probe_found (probe_found),
        .probe_index (probe_index),
        .cur_vpn2    (cur_vpn2),
        .cur_asid    (cur_asid),
        .tlb_wen     (tlb_wen),
        .tlb_widx    (tlb_widx),
        .tlb_wentry  (tlb_wentry)
    );

    tlb_entry_array #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_entries (
        .aclk    (aclk),
        .reset   (reset),
        .wen     (tlb_wen),
        .widx    (tlb_widx),
        .wentry  (tlb_wentry),
        .entries (entries)
    );

    // probe compares entry-hi against the whole table
    tlb_match #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_probe (
        .entries (entries),
        .vpn2    (cur_vpn2),
        .asid    (cur_asid),
        .found   (probe_found),
        .index   (probe_index)
    );

    tlb_translate #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_if_xlate (
        .aclk        (aclk),
        .reset       (reset),
        .req_valid   (if_req_valid),
        .vaddr       (if_vaddr),
        .is_store    (1'b0),          // fetch never stores
        .allowin     (if_allowin),
        .entries     (entries),
        .asid        (cur_asid),
        .rsp_valid   (if_rsp_valid),
        .rsp_allowin (if_rsp_allowin),
        .paddr       (if_paddr),
        .exc         (if_exc)
    );

    tlb_translate #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_dm_xlate (
        .aclk        (aclk),
        .reset       (reset),
        .req_valid   (dm_req_valid),
        .vaddr       (dm_vaddr),
        .is_store    (dm_is_store),
        .allowin     (dm_allowin),
        .entries     (entries),
        .asid        (cur_asid),
        .rsp_valid   (dm_rsp_valid),
        .rsp_allowin (dm_rsp_allowin),
        .paddr       (dm_paddr),
        .exc         (dm_exc)
    );

endmodule

// ==== src/cp0_tlb_regs.sv ====
module cp0_tlb_regs #(
    parameter int TLB_ENTRIES = mmu_pkg::DEFAULT_TLB_ENTRIES,
    localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
    input  logic                aclk,
    input  logic                reset,
    input  logic                wen,
    input  logic [4:0]          waddr,
    input  logic [31:0]         wdata,
    input  logic [4:0]          raddr,
    output logic [31:0]         rdata,
    input  logic                tlbwi,
    input  logic                tlbp,
    input  logic                probe_found,
    input  logic [IDX_W-1:0]    probe_index,
    output mmu_pkg::vpn2_t      cur_vpn2,
    output mmu_pkg::asid_t      cur_asid,
    output logic                tlb_wen,
    output logic [IDX_W-1:0]    tlb_widx,
    output mmu_pkg::tlb_entry_t tlb_wentry
);

    mmu_pkg::vpn2_t     hi_vpn2;
    mmu_pkg::asid_t     hi_asid;
    mmu_pkg::tlb_page_t lo0_page;
    mmu_pkg::tlb_page_t lo1_page;
    logic               lo0_g;
    logic               lo1_g;
    logic               idx_p;    // probe failed
    logic [IDX_W-1:0]   idx_q;

    // entry-lo word to page fields
    function automatic mmu_pkg::tlb_page_t lo_unpack(input logic [31:0] w);
        mmu_pkg::tlb_page_t pg;
        pg.pfn = w[mmu_pkg::ENTRYLO_PFN_LSB +: $bits(mmu_pkg::pfn_t)];
        pg.d   = w[mmu_pkg::ENTRYLO_D_BIT];
        pg.v   = w[mmu_pkg::ENTRYLO_V_BIT];
        return pg;
    endfunction

    function automatic logic [31:0] lo_pack(input mmu_pkg::tlb_page_t pg, input logic g);
        logic [31:0] w;
        w = '0;   // cache attribute bits stay zero
        w[mmu_pkg::ENTRYLO_PFN_LSB +: $bits(mmu_pkg::pfn_t)] = pg.pfn;
        w[mmu_pkg::ENTRYLO_D_BIT] = pg.d;
        w[mmu_pkg::ENTRYLO_V_BIT] = pg.v;
        w[mmu_pkg::ENTRYLO_G_BIT] = g;
        return w;
    endfunction

    always_ff @(posedge aclk) begin
        if (reset) begin
            hi_vpn2  <= '0;
            hi_asid  <= '0;
            lo0_page <= '0;
            lo1_page <= '0;
            lo0_g    <= 1'b0;
            lo1_g    <= 1'b0;
            idx_p    <= 1'b0;
            idx_q    <= '0;
        end else begin
            if (wen) begin
                case (waddr)
                    mmu_pkg::CP0_ENTRYHI: begin
                        hi_vpn2 <= wdata[mmu_pkg::ENTRYHI_VPN2_LSB +: $bits(mmu_pkg::vpn2_t)];
                        hi_asid <= wdata[$bits(mmu_pkg::asid_t)-1:0];
                    end
                    mmu_pkg::CP0_ENTRYLO0: begin
                        lo0_page <= lo_unpack(wdata);
                        lo0_g    <= wdata[mmu_pkg::ENTRYLO_G_BIT];
                    end
                    mmu_pkg::CP0_ENTRYLO1: begin
                        lo1_page <= lo_unpack(wdata);
                        lo1_g    <= wdata[mmu_pkg::ENTRYLO_G_BIT];
                    end
                    mmu_pkg::CP0_INDEX: begin
                        idx_q <= wdata[IDX_W-1:0];
                        idx_p <= wdata[mmu_pkg::INDEX_P_BIT];
                    end
                    default: ;
                endcase
            end
            if (tlbp) begin
                idx_p <= !probe_found;
                if (probe_found) begin
                    idx_q <= probe_index;  // index kept on a miss
                end
            end
        end
    end

    always_comb begin
        rdata = '0;
        case (raddr)
            mmu_pkg::CP0_ENTRYHI:  rdata = {hi_vpn2, 5'd0, hi_asid};
            mmu_pkg::CP0_ENTRYLO0: rdata = lo_pack(lo0_page, lo0_g);
            mmu_pkg::CP0_ENTRYLO1: rdata = lo_pack(lo1_page, lo1_g);
            mmu_pkg::CP0_INDEX:    rdata = {idx_p, 31'(idx_q)};
            default:               rdata = '0;
        endcase
    end

    assign cur_vpn2 = hi_vpn2;
    assign cur_asid = hi_asid;

    // tlbwi writes the slot named by index
    assign tlb_wen         = tlbwi;
    assign tlb_widx        = idx_q;
    assign tlb_wentry.vpn2 = hi_vpn2;
    assign tlb_wentry.asid = hi_asid;
    assign tlb_wentry.g    = lo0_g & lo1_g;   // global only if both halves agree
    assign tlb_wentry.p0   = lo0_page;
    assign tlb_wentry.p1   = lo1_page;

endmodule

// ==== src/tlb_translate.sv ====
module tlb_translate #(
    parameter int TLB_ENTRIES = mmu_pkg::DEFAULT_TLB_ENTRIES,
    localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
    input  logic                aclk,
    input  logic                reset,
    input  logic                req_valid,
    input  mmu_pkg::vaddr_t     vaddr,
    input  logic                is_store,
    output logic                allowin,
    input  mmu_pkg::tlb_entry_t entries [TLB_ENTRIES],
    input  mmu_pkg::asid_t      asid,
    output logic                rsp_valid,
    input  logic                rsp_allowin,
    output mmu_pkg::paddr_t     paddr,
    output mmu_pkg::mmu_exc_t   exc
);

    logic               hit;
    logic [IDX_W-1:0]   hit_idx;
    mmu_pkg::vpn2_t     req_vpn2;
    mmu_pkg::tlb_page_t page;
    mmu_pkg::mmu_exc_t  exc_d;
    mmu_pkg::paddr_t    paddr_d;

    assign req_vpn2 = vaddr[mmu_pkg::ODD_BIT + 1 +: $bits(mmu_pkg::vpn2_t)];

    tlb_match #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_match (
        .entries (entries),
        .vpn2    (req_vpn2),
        .asid    (asid),
        .found   (hit),
        .index   (hit_idx)
    );

    assign page = vaddr[mmu_pkg::ODD_BIT] ? entries[hit_idx].p1 : entries[hit_idx].p0;

    always_comb begin
        exc_d = mmu_pkg::EXC_NONE;
        if (!hit) begin
            exc_d = mmu_pkg::EXC_REFILL;
        end else if (!page.v) begin
            exc_d = mmu_pkg::EXC_INVALID;
        end else if (is_store && !page.d) begin
            exc_d = mmu_pkg::EXC_MODIFIED;
        end
    end

    // faulting lookups give a zero address
    assign paddr_d = (exc_d == mmu_pkg::EXC_NONE) ?
                     {page.pfn, vaddr[mmu_pkg::PAGE_OFFSET_W-1:0]} : '0;

    // empty, or the held result leaves this cycle
    assign allowin = !rsp_valid || rsp_allowin;

    always_ff @(posedge aclk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (allowin) begin
            rsp_valid <= req_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (req_valid && allowin) begin
            paddr <= paddr_d;
            exc   <= exc_d;
        end
    end

endmodule

// ==== src/tlb_match.sv ====
module tlb_match #(
    parameter int TLB_ENTRIES = mmu_pkg::DEFAULT_TLB_ENTRIES,
    localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
    input  mmu_pkg::tlb_entry_t entries [TLB_ENTRIES],
    input  mmu_pkg::vpn2_t      vpn2,
    input  mmu_pkg::asid_t      asid,
    output logic                found,
    output logic [IDX_W-1:0]    index
);

    logic [TLB_ENTRIES-1:0] hit;

    // walk downwards so the lowest hit wins the index
    always_comb begin
        hit   = '0;
        index = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entries[i].vpn2 == vpn2 &&
                (entries[i].g || entries[i].asid == asid)) begin
                hit[i] = 1'b1;
                index  = IDX_W'(i);
            end
        end
    end

    assign found = |hit;

endmodule

// ==== src/tlb_entry_array.sv ====
module tlb_entry_array #(
    parameter int TLB_ENTRIES = mmu_pkg::DEFAULT_TLB_ENTRIES,
    localparam int IDX_W = $clog2(TLB_ENTRIES)
) (
    input  logic                 aclk,
    input  logic                 reset,
    input  logic                 wen,
    input  logic [IDX_W-1:0]     widx,
    input  mmu_pkg::tlb_entry_t  wentry,
    output mmu_pkg::tlb_entry_t  entries [TLB_ENTRIES]
);

    // payload storage, the control bits live in the vectors below
    mmu_pkg::tlb_entry_t mem [TLB_ENTRIES];

    logic [TLB_ENTRIES-1:0] g_q;
    logic [TLB_ENTRIES-1:0] v0_q;
    logic [TLB_ENTRIES-1:0] v1_q;

    always_ff @(posedge aclk) begin
        if (wen) begin
            mem[widx] <= wentry;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            g_q  <= '0;
            v0_q <= '0;
            v1_q <= '0;
        end else if (wen) begin
            g_q[widx]  <= wentry.g;
            v0_q[widx] <= wentry.p0.v;
            v1_q[widx] <= wentry.p1.v;
        end
    end

    // every entry visible at once for the parallel compares
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            entries[i]      = mem[i];
            entries[i].g    = g_q[i];
            entries[i].p0.v = v0_q[i];
            entries[i].p1.v = v1_q[i];
        end
    end

endmodule

// ==== src/mmu_pkg.sv ====
package mmu_pkg;

    // address split
    localparam int PAGE_OFFSET_W = 12;
    localparam int ODD_BIT       = 12;  // selects even/odd page of a pair

    localparam int DEFAULT_TLB_ENTRIES = 16;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [18:0] vpn2_t;   // vaddr[31:13]
    typedef logic [19:0] pfn_t;
    typedef logic [7:0]  asid_t;

    // one page of a pair
    typedef struct packed {
        pfn_t pfn;
        logic d;   // dirty, i.e. writable
        logic v;
    } tlb_page_t;

    typedef struct packed {
        vpn2_t     vpn2;
        asid_t     asid;
        logic      g;     // ignore asid on compare
        tlb_page_t p0;    // even page
        tlb_page_t p1;    // odd page
    } tlb_entry_t;

    // translation result codes, in priority order below none
    typedef enum logic [1:0] {
        EXC_NONE     = 2'd0,
        EXC_REFILL   = 2'd1,  // no entry matched
        EXC_INVALID  = 2'd2,  // matching page not valid
        EXC_MODIFIED = 2'd3   // store to a clean page
    } mmu_exc_t;

    // cp0 register numbers
    localparam logic [4:0] CP0_INDEX    = 5'd0;
    localparam logic [4:0] CP0_ENTRYLO0 = 5'd2;
    localparam logic [4:0] CP0_ENTRYLO1 = 5'd3;
    localparam logic [4:0] CP0_ENTRYHI  = 5'd10;

    // field positions inside the cp0 words
    localparam int ENTRYHI_VPN2_LSB = 13;
    localparam int ENTRYLO_PFN_LSB  = 6;
    localparam int ENTRYLO_D_BIT    = 2;
    localparam int ENTRYLO_V_BIT    = 1;
    localparam int ENTRYLO_G_BIT    = 0;
    localparam int INDEX_P_BIT      = 31;

endpackage
